/* Makefile */
SRCS := $(shell cat cdr_top.f)

.PHONY: all run clean

all: obj_dir/Vcdr_top_tb

obj_dir/Vcdr_top_tb: cdr_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module cdr_top_tb -f cdr_top.f

run: obj_dir/Vcdr_top_tb
	obj_dir/Vcdr_top_tb | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* cdr_top.f */
verilog/cdr_pkg.sv
verilog/mm_pd.sv
verilog/mm_cdr.sv
verilog/cdr_regs_axil.sv
verilog/cdr_top.sv
sim/cdr_top_chk.sv
sim/cdr_top_tb.sv

/* sim/cdr_top_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cdr_top_chk (
    input wire logic clk_i,
    input wire logic rstb_i,
    input wire logic awready_i,
    input wire logic wready_i,
    input wire logic arready_i,
    input wire logic bvalid_i,
    input wire logic bready_i,
    input wire logic rvalid_i,
    input wire logic rready_i
);

    // responses stay up until the master takes them
    a_bvalid_hold: assert property (
        @(posedge clk_i) disable iff (!rstb_i) bvalid_i && !bready_i |=> bvalid_i
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge clk_i) disable iff (!rstb_i) rvalid_i && !rready_i |=> rvalid_i
    ) else $error("rvalid dropped before rready");

    // no new write while a response is pending
    a_no_aw_during_b: assert property (
        @(posedge clk_i) disable iff (!rstb_i) !(awready_i && bvalid_i)
    ) else $error("awready high while bvalid pending");

    a_idle_after_reset: assert property (
        @(posedge clk_i) $rose(rstb_i) |->
            !(awready_i || wready_i || arready_i || bvalid_i || rvalid_i)
    ) else $error("axi handshake outputs active right after reset");

endmodule

bind cdr_top cdr_top_chk cdr_top_chk_inst (
    .clk_i(clk),
    .rstb_i(ext_rstb),
    .awready_i(s_awready_o),
    .wready_i(s_wready_o),
    .arready_i(s_arready_o),
    .bvalid_i(s_bvalid_o),
    .bready_i(s_bready_i),
    .rvalid_i(s_rvalid_o),
    .rready_i(s_rready_i)
);

`default_nettype wire

/* sim/cdr_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cdr_top_tb;

    localparam int TIMEOUT_CYC = 50;
    localparam int CLAMP_AMT = 256;

    logic clk;
    logic ext_rstb;
    logic [7:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic bready;
    logic [7:0] araddr;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rready;
    cdr_pkg::adc_frame_t adc_frame;
    logic ramp_clock;
    logic [cdr_pkg::NOUT-1:0][cdr_pkg::NPI-1:0] pi_ctl;
    logic freq_lvl_cross;

    int errors;
    int checks;
    int cycle = 0;
    int snap_cycle;
    logic [31:0] rng_state;
    cdr_pkg::cdr_ctrl_t ctrl_base;

    cdr_top cdr_top_inst (
        .clk(clk),
        .ext_rstb(ext_rstb),
        .s_awaddr_i(awaddr),
        .s_awvalid_i(awvalid),
        .s_awready_o(awready),
        .s_wdata_i(wdata),
        .s_wstrb_i(wstrb),
        .s_wvalid_i(wvalid),
        .s_wready_o(wready),
        .s_bvalid_o(bvalid),
        .s_bresp_o(bresp),
        .s_bready_i(bready),
        .s_araddr_i(araddr),
        .s_arvalid_i(arvalid),
        .s_arready_o(arready),
        .s_rvalid_o(rvalid),
        .s_rdata_o(rdata),
        .s_rresp_o(rresp),
        .s_rready_i(rready),
        .adc_frame_i(adc_frame),
        .ramp_clock_i(ramp_clock),
        .pi_ctl_o(pi_ctl),
        .freq_lvl_cross_o(freq_lvl_cross)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // mueller-muller error over one frame where zero has sign +1
    function automatic int expected_pd(input cdr_pkg::adc_frame_t f, input int ofs,
                                       input bit inv);
        int sum;
        int cur;
        int prev;
        int lim;
        sum = ofs;
        lim = 1 << (cdr_pkg::PD_W - 1);
        for (int k = 1; k < cdr_pkg::NTI; k++) begin
            cur = $signed(f[k]);
            prev = $signed(f[k-1]);
            sum = sum + ((prev < 0) ? -cur : cur);
            sum = sum - ((cur < 0) ? -prev : prev);
        end
        if (sum > lim - 1) begin
            sum = lim - 1;
        end else if (sum < -lim) begin
            sum = -lim;
        end
        return inv ? -sum : sum;
    endfunction

    // readback form of a PD_W-bit signed field
    function automatic logic [31:0] pd_word(input int v);
        logic signed [cdr_pkg::PD_W-1:0] f;
        f = v[cdr_pkg::PD_W-1:0];
        return 32'(f);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %s done, %0d errors", name, errors - err_start);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        ext_rstb = 1'b0;
        ctrl_base = '0;
        repeat (2) @(posedge clk);
        #1;
        ext_rstb = 1'b1;
    endtask

    task automatic drive_frame(input int d0, input int d1, input int d2, input int d3);
        adc_frame[0] = 8'(d0);
        adc_frame[1] = 8'(d1);
        adc_frame[2] = 8'(d2);
        adc_frame[3] = 8'(d3);
    endtask

    ////////////////////////////////////////
    // axi4-lite master
    ////////////////////////////////////////

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int cnt;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        cnt = 0;
        while (!(awready && wready) && cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!(awready && wready)) begin
            $display("write to %02h was never accepted", addr);
            errors++;
            awvalid = 1'b0;
            wvalid = 1'b0;
        end else begin
            // config updates on the handshake edge
            @(posedge clk);
            #1;
            awvalid = 1'b0;
            wvalid = 1'b0;
            bready = 1'b1;
            cnt = 0;
            while (!bvalid && cnt < TIMEOUT_CYC) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (!bvalid) begin
                $display("write to %02h got no response", addr);
                errors++;
            end else begin
                check("s_bresp_o", 32'(bresp), 32'h0);
            end
            @(posedge clk);
            #1;
            bready = 1'b0;
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int cnt;
        data = '0;
        araddr = addr;
        arvalid = 1'b1;
        cnt = 0;
        while (!arready && cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!arready) begin
            $display("read from %02h was never accepted", addr);
            errors++;
            arvalid = 1'b0;
        end else begin
            @(posedge clk);
            #1;
            arvalid = 1'b0;
            rready = 1'b1;
            cnt = 0;
            while (!rvalid && cnt < TIMEOUT_CYC) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (!rvalid) begin
                $display("read from %02h returned no data", addr);
                errors++;
            end else begin
                data = rdata;
                check("s_rresp_o", 32'(rresp), 32'h0);
            end
            @(posedge clk);
            #1;
            rready = 1'b0;
        end
    endtask

    task automatic write_read_back(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] val;
        axi_write(addr, data);
        axi_read(addr, val);
        check($sformatf("s_rdata_o[%02h]", addr), val, data);
    endtask

    // sample_req low then high loads the snapshot two edges later
    task automatic take_snapshot(input logic [7:0] addr, output logic [31:0] value);
        axi_write(cdr_pkg::REG_CTRL, 32'(ctrl_base));
        axi_write(cdr_pkg::REG_CTRL, 32'(ctrl_base) | 32'h20);
        wait_cycles(2);
        snap_cycle = cycle;
        axi_read(addr, value);
    endtask

    task automatic phase_drift(output int cycles, output int codes);
        logic [31:0] p1;
        logic [31:0] p2;
        int c1;
        take_snapshot(cdr_pkg::REG_PHASE, p1);
        c1 = snap_cycle;
        wait_cycles(30);
        take_snapshot(cdr_pkg::REG_PHASE, p2);
        cycles = snap_cycle - c1;
        codes = $signed(p2) - $signed(p1);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset_regs();
        int err0;
        logic [31:0] val;
        err0 = errors;
        apply_reset();
        check("pi_ctl_o", 32'(pi_ctl), 32'h0);
        for (int a = 0; a <= 'h20; a += 4) begin
            axi_read(8'(a), val);
            check($sformatf("s_rdata_o[%02h]", a), val, 32'h0);
        end
        write_read_back(cdr_pkg::REG_GAIN, 32'h00150a03);
        write_read_back(cdr_pkg::REG_CLAMP, 32'h000abcde);
        write_read_back(cdr_pkg::REG_PDOFS, 32'hfffffe0f);
        write_read_back(cdr_pkg::REG_EXTPI, 32'h000000a5);
        write_read_back(cdr_pkg::REG_CTRL, 32'h0000001b);
        // unmapped address
        axi_read(8'h24, val);
        check("s_rdata_o[24]", val, 32'h0);
        report_test("reset_regs", err0);
    endtask

    task automatic test_ext_override();
        int err0;
        err0 = errors;
        apply_reset();
        drive_frame(0, 0, 0, 0);
        axi_write(cdr_pkg::REG_EXTPI, 32'h5a);
        ctrl_base.en_ext_pi_ctl = 1'b1;
        axi_write(cdr_pkg::REG_CTRL, 32'(ctrl_base));
        for (int k = 0; k < cdr_pkg::NOUT; k++) begin
            check($sformatf("pi_ctl_o[%0d]", k), 32'(pi_ctl[k]), 32'h5a);
        end
        ctrl_base.en_ext_pi_ctl = 1'b0;
        axi_write(cdr_pkg::REG_CTRL, 32'(ctrl_base));
        // zero frame keeps the loop at code zero
        for (int k = 0; k < cdr_pkg::NOUT; k++) begin
            check($sformatf("pi_ctl_o[%0d]", k), 32'(pi_ctl[k]), 32'h0);
        end
        report_test("ext_override", err0);
    endtask

    task automatic test_phase_detector();
        int err0;
        int ofs;
        logic [31:0] val;
        err0 = errors;
        apply_reset();
        for (int i = 0; i < 12; i++) begin
            rng_state = xorshift32(rng_state);
            adc_frame = rng_state;
            rng_state = xorshift32(rng_state);
            ofs = int'(rng_state % 601) - 300;
            if (i == 0) begin
                adc_frame[1] = '0;
            end else if (i == 1) begin
                drive_frame(-128, 0, 1, 127);
                ofs = 300;
            end else if (i == 2) begin
                drive_frame(127, 1, 0, -128);
                ofs = -300;
            end
            axi_write(cdr_pkg::REG_PDOFS, 32'(ofs));
            ctrl_base.invert = i[0];
            take_snapshot(cdr_pkg::REG_PDERR, val);
            check("pd_err", val, pd_word(expected_pd(adc_frame, ofs, i[0])));
        end
        report_test("phase_detector", err0);
    endtask

    task automatic test_proportional();
        int err0;
        logic [31:0] p1;
        logic [31:0] p2;
        err0 = errors;
        for (int mode = 0; mode < 3; mode++) begin
            apply_reset();
            // error of +30 per frame
            drive_frame(10, 20, 30, 40);
            axi_write(cdr_pkg::REG_GAIN, 32'h4);
            ctrl_base.invert = (mode == 1);
            if (mode == 2) begin
                axi_write(cdr_pkg::REG_PDOFS, 32'(-30));
            end
            take_snapshot(cdr_pkg::REG_PHASE, p1);
            take_snapshot(cdr_pkg::REG_PHASE, p2);
            if (mode == 0) begin
                check("phase_est rising", 32'($signed(p2) > $signed(p1)), 32'h1);
            end else if (mode == 1) begin
                check("phase_est falling", 32'($signed(p2) < $signed(p1)), 32'h1);
            end else begin
                check("phase_est", p2, p1);
            end
        end
        report_test("proportional", err0);
    endtask

    task automatic test_clamp();
        int err0;
        int cycles;
        int codes;
        int bound;
        err0 = errors;
        for (int mode = 0; mode < 2; mode++) begin
            apply_reset();
            drive_frame(10, 20, 30, 40);
            axi_write(cdr_pkg::REG_GAIN, 32'h6);
            axi_write(cdr_pkg::REG_CLAMP, 32'(CLAMP_AMT));
            ctrl_base.en_clamp = (mode == 0);
            phase_drift(cycles, codes);
            bound = (cycles + 3) * CLAMP_AMT / (1 << cdr_pkg::PHASE_SHIFT) + 1;
            if (mode == 0) begin
                check("clamped phase drift", 32'(codes <= bound), 32'h1);
            end else begin
                check("unclamped phase drift", 32'(codes > bound), 32'h1);
            end
        end
        report_test("clamp", err0);
    endtask

    task automatic test_freq_ramp();
        int err0;
        int cnt;
        logic [31:0] val;
        logic [31:0] p1;
        logic [31:0] p2;
        err0 = errors;

        // integrator keeps the phase moving after the error is gone
        apply_reset();
        drive_frame(10, 20, 30, 40);
        axi_write(cdr_pkg::REG_GAIN, 32'h0);
        ctrl_base.en_freq_est = 1'b1;
        take_snapshot(cdr_pkg::REG_FREQ, val);
        check("freq_est positive", 32'($signed(val) > 0), 32'h1);
        drive_frame(0, 0, 0, 0);
        take_snapshot(cdr_pkg::REG_PHASE, p1);
        wait_cycles(20);
        take_snapshot(cdr_pkg::REG_PHASE, p2);
        check("phase_est still rising", 32'($signed(p2) > $signed(p1)), 32'h1);

        for (int s = 0; s < 2; s++) begin
            // with the integrator off the frequency update is the scaled error
            apply_reset();
            if (s == 0) begin
                drive_frame(10, 20, 30, 40);
            end else begin
                drive_frame(40, 30, 20, 10);
            end
            axi_write(cdr_pkg::REG_GAIN, 32'h0300);
            take_snapshot(cdr_pkg::REG_FREQ, val);
            check("freq_est", val, 32'(expected_pd(adc_frame, 0, 1'b0) <<< 3));

            // ramp estimator on the high half of the ramp clock
            apply_reset();
            ramp_clock = 1'b1;
            axi_write(cdr_pkg::REG_GAIN, 32'h020000);
            ctrl_base.en_ramp_est = 1'b1;
            axi_write(cdr_pkg::REG_CTRL, 32'(ctrl_base));
            if (s == 0) begin
                cnt = 0;
                while (!freq_lvl_cross && cnt < TIMEOUT_CYC) begin
                    @(posedge clk);
                    #1;
                    cnt++;
                end
                check("freq_lvl_cross_o", 32'(freq_lvl_cross), 32'h1);
            end
            take_snapshot(cdr_pkg::REG_RAMP, val);
            if (s == 0) begin
                check("ramp_est positive", 32'($signed(val) > 0), 32'h1);
            end else begin
                check("ramp_est negative", 32'($signed(val) < 0), 32'h1);
            end
            ramp_clock = 1'b0;
        end
        report_test("freq_ramp", err0);
    endtask

    initial begin
        ext_rstb = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        adc_frame = '0;
        ramp_clock = 1'b0;
        errors = 0;
        checks = 0;
        snap_cycle = 0;
        rng_state = 32'hdd57371c;
        ctrl_base = '0;

        test_reset_regs();
        test_ext_override();
        test_phase_detector();
        test_proportional();
        test_clamp();
        test_freq_ramp();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cdr_pkg.sv */
`default_nettype none

package cdr_pkg;

    ////////////////////////////////////////
    // datapath sizes
    ////////////////////////////////////////

    localparam int NADC = 8;
    localparam int NTI = 4;
    localparam int NPI = 8;
    localparam int NOUT = 2;
    localparam int GAIN_W = 5;
    localparam int PHASE_SHIFT = 10;
    localparam int ACC_W = NADC + 2 + PHASE_SHIFT;
    localparam int PD_W = NADC + 2;

    // axi4-lite bus widths
    localparam int AXI_AW = 8;
    localparam int AXI_DW = 32;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    ////////////////////////////////////////
    // register map, byte addresses
    ////////////////////////////////////////

    localparam logic [AXI_AW-1:0] REG_CTRL = 8'h00;
    localparam logic [AXI_AW-1:0] REG_GAIN = 8'h04;
    localparam logic [AXI_AW-1:0] REG_CLAMP = 8'h08;
    localparam logic [AXI_AW-1:0] REG_PDOFS = 8'h0C;
    localparam logic [AXI_AW-1:0] REG_EXTPI = 8'h10;
    localparam logic [AXI_AW-1:0] REG_PHASE = 8'h14;
    localparam logic [AXI_AW-1:0] REG_FREQ = 8'h18;
    localparam logic [AXI_AW-1:0] REG_RAMP = 8'h1C;
    localparam logic [AXI_AW-1:0] REG_PDERR = 8'h20;

    // one adc sample, lane 0 is the earliest in a frame
    typedef logic signed [NADC-1:0] adc_sample_t;
    typedef adc_sample_t [NTI-1:0] adc_frame_t;

    // first member is the msb, so invert lands on bit 0
    typedef struct packed {
        logic sample_req;
        logic en_ext_pi_ctl;
        logic en_clamp;
        logic en_ramp_est;
        logic en_freq_est;
        logic invert;
    } cdr_ctrl_t;

    typedef struct packed {
        logic [GAIN_W-1:0] kp;
        logic [GAIN_W-1:0] ki;
        logic [GAIN_W-1:0] kr;
        cdr_ctrl_t ctrl;
        logic [ACC_W-1:0] clamp_amt;
        logic signed [PD_W-1:0] pd_offset;
        logic [NPI-1:0] ext_pi_ctl;
    } cdr_cfg_t;

    typedef struct packed {
        logic signed [PD_W-1:0] phase_est;
        logic signed [ACC_W-1:0] freq_est;
        logic signed [ACC_W-1:0] ramp_est;
        logic signed [PD_W-1:0] pd_err;
    } cdr_status_t;

endpackage

`default_nettype wire

/* verilog/cdr_regs_axil.sv */
`timescale 1ns/10ps
`default_nettype none

module cdr_regs_axil (
    input wire logic clk,
    input wire logic ext_rstb,
    input wire logic [cdr_pkg::AXI_AW-1:0] s_awaddr_i,
    input wire logic s_awvalid_i,
    output logic s_awready_o,
    input wire logic [cdr_pkg::AXI_DW-1:0] s_wdata_i,
    input wire logic [cdr_pkg::AXI_DW/8-1:0] s_wstrb_i,
    input wire logic s_wvalid_i,
    output logic s_wready_o,
    output logic s_bvalid_o,
    output logic [1:0] s_bresp_o,
    input wire logic s_bready_i,
    input wire logic [cdr_pkg::AXI_AW-1:0] s_araddr_i,
    input wire logic s_arvalid_i,
    output logic s_arready_o,
    output logic s_rvalid_o,
    output logic [cdr_pkg::AXI_DW-1:0] s_rdata_o,
    output logic [1:0] s_rresp_o,
    input wire logic s_rready_i,
    input wire cdr_pkg::cdr_status_t status_i,
    output cdr_pkg::cdr_cfg_t cfg_o
);

    logic wr_ready_q;
    logic ar_ready_q;
    logic wr_fire;
    logic rd_fire;
    logic [cdr_pkg::AXI_DW-1:0] rd_word;

    assign s_awready_o = wr_ready_q;
    assign s_wready_o = wr_ready_q;
    assign s_arready_o = ar_ready_q;
    assign s_bresp_o = cdr_pkg::AXI_RESP_OKAY;
    assign s_rresp_o = cdr_pkg::AXI_RESP_OKAY;

    assign wr_fire = s_awvalid_i && s_wvalid_i && wr_ready_q;
    assign rd_fire = s_arvalid_i && ar_ready_q;

    ////////////////////////////////////////
    // write channel
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            wr_ready_q <= 1'b0;
            s_bvalid_o <= 1'b0;
            cfg_o <= '0;
        end else begin
            // address and data accepted together in a one-cycle pulse
            wr_ready_q <= s_awvalid_i && s_wvalid_i && !wr_ready_q && !s_bvalid_o;
            if (wr_fire) begin
                s_bvalid_o <= 1'b1;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
            // only full-word writes change a register
            if (wr_fire && (&s_wstrb_i)) begin
                case (s_awaddr_i)
                    cdr_pkg::REG_CTRL: begin
                        cfg_o.ctrl <= cdr_pkg::cdr_ctrl_t'(s_wdata_i[5:0]);
                    end
                    // kp in [4:0], ki in [12:8], kr in [20:16]
                    cdr_pkg::REG_GAIN: begin
                        cfg_o.kp <= s_wdata_i[cdr_pkg::GAIN_W-1:0];
                        cfg_o.ki <= s_wdata_i[8+:cdr_pkg::GAIN_W];
                        cfg_o.kr <= s_wdata_i[16+:cdr_pkg::GAIN_W];
                    end
                    cdr_pkg::REG_CLAMP: begin
                        cfg_o.clamp_amt <= s_wdata_i[cdr_pkg::ACC_W-1:0];
                    end
                    cdr_pkg::REG_PDOFS: begin
                        cfg_o.pd_offset <= s_wdata_i[cdr_pkg::PD_W-1:0];
                    end
                    cdr_pkg::REG_EXTPI: begin
                        cfg_o.ext_pi_ctl <= s_wdata_i[cdr_pkg::NPI-1:0];
                    end
                    default: begin
                        cfg_o <= cfg_o;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // read channel
    ////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        case (s_araddr_i)
            cdr_pkg::REG_CTRL: rd_word[5:0] = cfg_o.ctrl;
            cdr_pkg::REG_GAIN: begin
                rd_word[cdr_pkg::GAIN_W-1:0] = cfg_o.kp;
                rd_word[8+:cdr_pkg::GAIN_W] = cfg_o.ki;
                rd_word[16+:cdr_pkg::GAIN_W] = cfg_o.kr;
            end
            cdr_pkg::REG_CLAMP: rd_word[cdr_pkg::ACC_W-1:0] = cfg_o.clamp_amt;
            // signed fields come back sign-extended
            cdr_pkg::REG_PDOFS: rd_word = 32'(cfg_o.pd_offset);
            cdr_pkg::REG_EXTPI: rd_word[cdr_pkg::NPI-1:0] = cfg_o.ext_pi_ctl;
            cdr_pkg::REG_PHASE: rd_word = 32'(status_i.phase_est);
            cdr_pkg::REG_FREQ: rd_word = 32'(status_i.freq_est);
            cdr_pkg::REG_RAMP: rd_word = 32'(status_i.ramp_est);
            cdr_pkg::REG_PDERR: rd_word = 32'(status_i.pd_err);
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ar_ready_q <= 1'b0;
            s_rvalid_o <= 1'b0;
        end else begin
            ar_ready_q <= s_arvalid_i && !ar_ready_q && !s_rvalid_o;
            if (rd_fire) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    // read data held with rvalid
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_rdata_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* verilog/cdr_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cdr_top (
    input wire logic clk,
    input wire logic ext_rstb,
    input wire logic [cdr_pkg::AXI_AW-1:0] s_awaddr_i,
    input wire logic s_awvalid_i,
    output logic s_awready_o,
    input wire logic [cdr_pkg::AXI_DW-1:0] s_wdata_i,
    input wire logic [cdr_pkg::AXI_DW/8-1:0] s_wstrb_i,
    input wire logic s_wvalid_i,
    output logic s_wready_o,
    output logic s_bvalid_o,
    output logic [1:0] s_bresp_o,
    input wire logic s_bready_i,
    input wire logic [cdr_pkg::AXI_AW-1:0] s_araddr_i,
    input wire logic s_arvalid_i,
    output logic s_arready_o,
    output logic s_rvalid_o,
    output logic [cdr_pkg::AXI_DW-1:0] s_rdata_o,
    output logic [1:0] s_rresp_o,
    input wire logic s_rready_i,
    input wire cdr_pkg::adc_frame_t adc_frame_i,
    input wire logic ramp_clock_i,
    output logic [cdr_pkg::NOUT-1:0][cdr_pkg::NPI-1:0] pi_ctl_o,
    output logic freq_lvl_cross_o
);

    cdr_pkg::cdr_cfg_t cfg;
    cdr_pkg::cdr_status_t status;

    // register block drives the configuration and reads the snapshot
    cdr_regs_axil cdr_regs_axil_inst (
        .clk(clk),
        .ext_rstb(ext_rstb),
        .s_awaddr_i(s_awaddr_i),
        .s_awvalid_i(s_awvalid_i),
        .s_awready_o(s_awready_o),
        .s_wdata_i(s_wdata_i),
        .s_wstrb_i(s_wstrb_i),
        .s_wvalid_i(s_wvalid_i),
        .s_wready_o(s_wready_o),
        .s_bvalid_o(s_bvalid_o),
        .s_bresp_o(s_bresp_o),
        .s_bready_i(s_bready_i),
        .s_araddr_i(s_araddr_i),
        .s_arvalid_i(s_arvalid_i),
        .s_arready_o(s_arready_o),
        .s_rvalid_o(s_rvalid_o),
        .s_rdata_o(s_rdata_o),
        .s_rresp_o(s_rresp_o),
        .s_rready_i(s_rready_i),
        .status_i(status),
        .cfg_o(cfg)
    );

    mm_cdr mm_cdr_inst (
        .clk(clk),
        .ext_rstb(ext_rstb),
        .frame_i(adc_frame_i),
        .ramp_clock_i(ramp_clock_i),
        .cfg_i(cfg),
        .pi_ctl_o(pi_ctl_o),
        .freq_lvl_cross_o(freq_lvl_cross_o),
        .status_o(status)
    );

endmodule

`default_nettype wire

/* verilog/mm_cdr.sv */
`timescale 1ns/10ps
`default_nettype none

module mm_cdr (
    input wire logic clk,
    input wire logic ext_rstb,
    input wire cdr_pkg::adc_frame_t frame_i,
    input wire logic ramp_clock_i,
    input wire cdr_pkg::cdr_cfg_t cfg_i,
    output logic [cdr_pkg::NOUT-1:0][cdr_pkg::NPI-1:0] pi_ctl_o,
    output logic freq_lvl_cross_o,
    output cdr_pkg::cdr_status_t status_o
);

    typedef enum logic [1:0] {SAMPLE, WAIT, READY} sampler_state_t;

    sampler_state_t sampler_state;

    logic signed [cdr_pkg::PD_W-1:0] pd_err;
    logic signed [cdr_pkg::PD_W-1:0] phase_error;
    logic signed [cdr_pkg::PD_W-1:0] phase_out;
    logic signed [cdr_pkg::ACC_W-1:0] err_ext;
    logic signed [cdr_pkg::ACC_W-1:0] err_kp;
    logic signed [cdr_pkg::ACC_W-1:0] err_ki;
    logic signed [cdr_pkg::ACC_W-1:0] err_kr;
    logic signed [cdr_pkg::ACC_W-1:0] ramp_pls_q;
    logic signed [cdr_pkg::ACC_W-1:0] ramp_pls_upd;
    logic signed [cdr_pkg::ACC_W-1:0] ramp_pls_d;
    logic signed [cdr_pkg::ACC_W-1:0] ramp_neg_q;
    logic signed [cdr_pkg::ACC_W-1:0] ramp_neg_upd;
    logic signed [cdr_pkg::ACC_W-1:0] ramp_neg_d;
    logic signed [cdr_pkg::ACC_W-1:0] freq_upd;
    logic signed [cdr_pkg::ACC_W-1:0] prev_freq_upd_q;
    logic signed [cdr_pkg::ACC_W-1:0] freq_est_q;
    logic signed [cdr_pkg::ACC_W-1:0] freq_est_d;
    logic signed [cdr_pkg::ACC_W:0] freq_diff;
    logic signed [cdr_pkg::ACC_W-1:0] phase_upd;
    logic signed [cdr_pkg::ACC_W-1:0] phase_upd_clamped;
    logic signed [cdr_pkg::ACC_W-1:0] phase_est_q;
    logic signed [cdr_pkg::ACC_W-1:0] clamp_min;
    logic signed [cdr_pkg::ACC_W-1:0] clamp_max;
    logic ramp_clock_ff;
    logic ramp_clock_sync;

    mm_pd mm_pd_inst (
        .frame_i(frame_i),
        .pd_offset_i(cfg_i.pd_offset),
        .pd_err_o(pd_err)
    );

    assign phase_error = cfg_i.ctrl.invert ? -pd_err : pd_err;

    // widen before shifting by the loop gains
    assign err_ext = phase_error;
    assign err_kp = err_ext <<< cfg_i.kp;
    assign err_ki = err_ext <<< cfg_i.ki;
    assign err_kr = err_ext <<< cfg_i.kr;

    ////////////////////////////////////////
    // loop filter
    ////////////////////////////////////////

    always_comb begin
        // two-sided ramp estimate, steered by the raw ramp clock
        ramp_pls_upd = ramp_pls_q;
        ramp_neg_upd = ramp_neg_q;
        if (ramp_clock_i) begin
            ramp_pls_upd = ramp_pls_q + err_kr;
        end else begin
            ramp_neg_upd = ramp_neg_q + err_kr;
        end
        ramp_pls_d = cfg_i.ctrl.en_ramp_est ? ramp_pls_upd : '0;
        ramp_neg_d = cfg_i.ctrl.en_ramp_est ? ramp_neg_upd : '0;

        freq_upd = err_ki + (ramp_clock_sync ? ramp_pls_q : -ramp_neg_q);
        freq_est_d = freq_est_q;
        if (cfg_i.ctrl.en_freq_est) begin
            freq_est_d = freq_est_q + freq_upd;
        end

        phase_upd = err_kp + freq_est_q;
        phase_upd_clamped = phase_upd;
        if (cfg_i.ctrl.en_clamp) begin
            if (phase_upd < clamp_min) begin
                phase_upd_clamped = clamp_min;
            end else if (phase_upd > clamp_max) begin
                phase_upd_clamped = clamp_max;
            end
        end
    end

    assign freq_diff = freq_upd - prev_freq_upd_q;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_est_q <= '0;
            freq_est_q <= '0;
            prev_freq_upd_q <= '0;
            ramp_pls_q <= '0;
            ramp_neg_q <= '0;
            clamp_min <= '0;
            clamp_max <= '0;
            ramp_clock_ff <= 1'b0;
            ramp_clock_sync <= 1'b0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            phase_est_q <= phase_est_q + phase_upd_clamped;
            freq_est_q <= freq_est_d;
            prev_freq_upd_q <= freq_upd;
            ramp_pls_q <= ramp_pls_d;
            ramp_neg_q <= ramp_neg_d;
            clamp_min <= -cfg_i.clamp_amt;
            clamp_max <= cfg_i.clamp_amt;
            // ramp clock comes from another domain
            ramp_clock_ff <= ramp_clock_i;
            ramp_clock_sync <= ramp_clock_ff;
            freq_lvl_cross_o <= freq_diff > 0;
        end
    end

    ////////////////////////////////////////
    // interpolator codes
    ////////////////////////////////////////

    assign phase_out = phase_est_q[cdr_pkg::ACC_W-1:cdr_pkg::PHASE_SHIFT];

    for (genvar k = 0; k < cdr_pkg::NOUT; k++) begin : g_pi
        assign pi_ctl_o[k] = cfg_i.ctrl.en_ext_pi_ctl ? cfg_i.ext_pi_ctl :
                                                        phase_out[cdr_pkg::NPI-1:0];
    end

    // status snapshot, one capture per rising sample_req
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            status_o <= '0;
            sampler_state <= WAIT;
        end else begin
            case (sampler_state)
                SAMPLE: begin
                    status_o.phase_est <= phase_out;
                    status_o.freq_est <= freq_upd;
                    status_o.ramp_est <= ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;
                    status_o.pd_err <= phase_error;
                    sampler_state <= WAIT;
                end
                WAIT: begin
                    sampler_state <= cfg_i.ctrl.sample_req ? WAIT : READY;
                end
                READY: begin
                    sampler_state <= cfg_i.ctrl.sample_req ? SAMPLE : READY;
                end
                default: begin
                    sampler_state <= WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/mm_pd.sv */
`timescale 1ns/10ps
`default_nettype none

module mm_pd (
    input wire cdr_pkg::adc_frame_t frame_i,
    input wire logic signed [cdr_pkg::PD_W-1:0] pd_offset_i,
    output logic signed [cdr_pkg::PD_W-1:0] pd_err_o
);

    // three guard bits cover three lane pairs plus the offset
    logic signed [cdr_pkg::PD_W+2:0] sum;
    logic signed [cdr_pkg::PD_W+2:0] cur;
    logic signed [cdr_pkg::PD_W+2:0] prev;
    logic signed [cdr_pkg::PD_W+2:0] cur_sgn;
    logic signed [cdr_pkg::PD_W+2:0] prev_sgn;
    logic [3:0] top_bits;
    logic ovf;

    ////////////////////////////////////////
    // mueller-muller sum over lane pairs
    ////////////////////////////////////////

    always_comb begin
        sum = pd_offset_i;
        cur = '0;
        prev = '0;
        cur_sgn = '0;
        prev_sgn = '0;
        for (int k = 1; k < cdr_pkg::NTI; k++) begin
            cur = frame_i[k];
            prev = frame_i[k-1];
            // d[k] times sign(d[k-1]), zero counts as positive
            prev_sgn = prev[cdr_pkg::PD_W+2] ? -cur : cur;
            // d[k-1] times sign(d[k])
            cur_sgn = cur[cdr_pkg::PD_W+2] ? -prev : prev;
            sum = sum + prev_sgn - cur_sgn;
        end
    end

    // saturate to the output width
    assign top_bits = sum[cdr_pkg::PD_W+2:cdr_pkg::PD_W-1];
    assign ovf = !((&top_bits) || !(|top_bits));

    always_comb begin
        if (ovf) begin
            pd_err_o = {sum[cdr_pkg::PD_W+2], {(cdr_pkg::PD_W-1){~sum[cdr_pkg::PD_W+2]}}};
        end else begin
            pd_err_o = sum[cdr_pkg::PD_W-1:0];
        end
    end

endmodule

`default_nettype wire
